// File: src/mc_pkg.sv
package mc_pkg;

	localparam int ACC_W = 32; // Holds 16 full-scale products without overflow.

	// Signed input sample shared by all cores.
	typedef logic signed [18:0] sample_t;

	typedef logic signed [7:0] weight_t;

	// Result after clamping to 28 bits.
	typedef logic signed [27:0] result_t;

	typedef logic [4:0] win_len_t; // Legal values are 1 to 16.

	typedef logic [3:0] out_code_t;

	localparam out_code_t OUT_NONE   = 4'd0;
	localparam out_code_t OUT_RESULT = 4'd1;
	localparam out_code_t OUT_SAT    = 4'd2; // The window sum was clamped.

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_STAGGER,
		SEQ_RUN
	} seq_state_t;

endpackage

// File: src/start_sequencer.sv
module start_sequencer #(
	parameter int N_CORES = 4,
	parameter int STAGGER = 15
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  mc_pkg::win_len_t     win_len,
	output logic [N_CORES-1:0]   run,
	output mc_pkg::win_len_t     win_len_q
);

	localparam int CNT_W = $clog2(STAGGER + 1);
	localparam int IDX_W = $clog2(N_CORES + 1);

	mc_pkg::seq_state_t state;
	logic [CNT_W-1:0]   cnt;
	logic [IDX_W-1:0]   idx; // Next core to be released.

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= mc_pkg::SEQ_IDLE;
			run       <= '0;
			cnt       <= '0;
			idx       <= '0;
			win_len_q <= 5'd16;
		end else begin
			case (state)
				mc_pkg::SEQ_IDLE: begin
					if (start) begin
						win_len_q <= win_len;
						run       <= {{(N_CORES - 1){1'b0}}, 1'b1};
						cnt       <= '0;
						idx       <= IDX_W'(1);
						state     <= (N_CORES == 1) ? mc_pkg::SEQ_RUN : mc_pkg::SEQ_STAGGER;
					end
				end
				mc_pkg::SEQ_STAGGER: begin
					if (cnt == CNT_W'(STAGGER - 1)) begin
						run <= run | (N_CORES'(1) << idx); // Release one more core.
						cnt <= '0;
						idx <= idx + 1'b1;
						if (idx == IDX_W'(N_CORES - 1)) begin
							state <= mc_pkg::SEQ_RUN;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				mc_pkg::SEQ_RUN: begin
					state <= mc_pkg::SEQ_RUN; // Start pulses are ignored until reset.
				end
				default: begin
					state <= mc_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/neuron_core.sv
module neuron_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               run,
	input  mc_pkg::win_len_t   win_len,
	input  mc_pkg::sample_t    sample_in,
	input  logic               weight_wr,
	input  mc_pkg::weight_t    weight_data,
	output mc_pkg::result_t    result,
	output mc_pkg::out_code_t  code
);

	localparam int RES_W  = $bits(mc_pkg::result_t);
	localparam int PROD_W = $bits(mc_pkg::sample_t) + $bits(mc_pkg::weight_t);

	mc_pkg::weight_t                weight_q;
	logic signed [PROD_W-1:0]       product;
	logic signed [mc_pkg::ACC_W-1:0] acc;
	logic signed [mc_pkg::ACC_W-1:0] total;
	mc_pkg::win_len_t               count;
	logic                           last;
	logic                           fits;
	mc_pkg::result_t                clamped;

	always_comb begin
		product = sample_in * weight_q;
		total   = acc + product; // Product is sign extended to the accumulator width.
		last    = (count == win_len - 5'd1);

		// The sum fits when all bits above the result sign bit agree with it.
		fits = (&total[mc_pkg::ACC_W-1:RES_W-1]) | (~|total[mc_pkg::ACC_W-1:RES_W-1]);

		if (fits) begin
			clamped = total[RES_W-1:0];
		end else if (total[mc_pkg::ACC_W-1]) begin
			clamped = {1'b1, {(RES_W - 1){1'b0}}};
		end else begin
			clamped = {1'b0, {(RES_W - 1){1'b1}}};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			weight_q <= 8'sd1;
			acc      <= '0;
			count    <= '0;
			code     <= mc_pkg::OUT_NONE;
		end else begin
			code <= mc_pkg::OUT_NONE;
			if (weight_wr) begin
				weight_q <= weight_data; // Used from the next sample on.
			end
			if (run) begin
				if (last) begin
					acc   <= '0; // Next window starts on the following edge.
					count <= '0;
					code  <= fits ? mc_pkg::OUT_RESULT : mc_pkg::OUT_SAT;
				end else begin
					acc   <= total;
					count <= count + 5'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (run && last) begin
			result <= clamped;
		end
	end

endmodule

// File: src/core_array.sv
module core_array #(
	parameter int N_CORES = 4
) (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic [N_CORES-1:0]                               run,
	input  mc_pkg::win_len_t                                 win_len,
	input  mc_pkg::sample_t                                  sample_in,
	input  logic                                             weight_wr,
	input  logic [$clog2(N_CORES)-1:0]                       weight_addr,
	input  mc_pkg::weight_t                                  weight_data,
	output logic [N_CORES*$bits(mc_pkg::result_t)-1:0]       core_result,
	output logic [N_CORES*$bits(mc_pkg::out_code_t)-1:0]     core_code
);

	localparam int RES_W  = $bits(mc_pkg::result_t);
	localparam int CODE_W = $bits(mc_pkg::out_code_t);
	localparam int IDX_W  = $clog2(N_CORES);

	logic [N_CORES-1:0] wr_sel;

	for (genvar c = 0; c < N_CORES; c++) begin : g_core
		assign wr_sel[c] = weight_wr && (weight_addr == IDX_W'(c));

		neuron_core i_core (
			.clk         (clk),
			.rst         (rst),
			.run         (run[c]),
			.win_len     (win_len),
			.sample_in   (sample_in),
			.weight_wr   (wr_sel[c]),
			.weight_data (weight_data),
			.result      (core_result[c*RES_W +: RES_W]),
			.code        (core_code[c*CODE_W +: CODE_W])
		);
	end

endmodule

// File: src/result_arbiter.sv
module result_arbiter #(
	parameter int N_CORES = 4
) (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic [N_CORES*$bits(mc_pkg::result_t)-1:0]   core_result,
	input  logic [N_CORES*$bits(mc_pkg::out_code_t)-1:0] core_code,
	output mc_pkg::result_t                              result,
	output mc_pkg::out_code_t                            result_code,
	output logic [$clog2(N_CORES)-1:0]                   result_core,
	output logic [15:0]                                  drop_count
);

	localparam int RES_W  = $bits(mc_pkg::result_t);
	localparam int CODE_W = $bits(mc_pkg::out_code_t);
	localparam int IDX_W  = $clog2(N_CORES);
	localparam int CNT_W  = $clog2(N_CORES + 1);

	logic               sel_valid;
	logic [IDX_W-1:0]   sel_idx;
	mc_pkg::result_t    sel_result;
	mc_pkg::out_code_t  sel_code;
	logic [CNT_W-1:0]   n_valid;
	logic [CNT_W-1:0]   drops;
	logic [16:0]        drop_sum;

	always_comb begin
		sel_valid  = 1'b0;
		sel_idx    = '0;
		sel_result = '0;
		sel_code   = mc_pkg::OUT_NONE;
		n_valid    = '0;
		// Walk down so the lowest valid index is the one left selected.
		for (int c = N_CORES - 1; c >= 0; c--) begin
			if (core_code[c*CODE_W +: CODE_W] != mc_pkg::OUT_NONE) begin
				sel_valid  = 1'b1;
				sel_idx    = IDX_W'(c);
				sel_result = core_result[c*RES_W +: RES_W];
				sel_code   = core_code[c*CODE_W +: CODE_W];
				n_valid    = n_valid + 1'b1;
			end
		end
		drops    = sel_valid ? n_valid - 1'b1 : '0;
		drop_sum = drop_count + drops;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result_code <= mc_pkg::OUT_NONE;
			drop_count  <= '0;
		end else begin
			result_code <= sel_code;
			drop_count  <= drop_sum[16] ? 16'hffff : drop_sum[15:0]; // Saturates.
		end
	end

	always_ff @(posedge clk) begin
		if (sel_valid) begin
			result      <= sel_result;
			result_core <= sel_idx;
		end
	end

endmodule

// File: src/multicore.sv
module multicore #(
	parameter int N_CORES = 4,
	parameter int STAGGER = 15
) (
	input  logic                           clk,
	input  logic                           rst,
	input  mc_pkg::sample_t                sample_in,
	input  logic                           start,
	input  mc_pkg::win_len_t               win_len,
	input  logic                           weight_wr,
	input  logic [$clog2(N_CORES)-1:0]     weight_addr,
	input  mc_pkg::weight_t                weight_data,
	output mc_pkg::result_t                result,
	output mc_pkg::out_code_t              result_code,
	output logic [$clog2(N_CORES)-1:0]     result_core,
	output logic [N_CORES-1:0]             active,
	output logic [15:0]                    drop_count
);

	mc_pkg::win_len_t                                   win_len_q;
	logic [N_CORES*$bits(mc_pkg::result_t)-1:0]         core_result;
	logic [N_CORES*$bits(mc_pkg::out_code_t)-1:0]       core_code;

	// The run levels double as the active mask.
	start_sequencer #(
		.N_CORES (N_CORES),
		.STAGGER (STAGGER)
	) i_seq (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.win_len   (win_len),
		.run       (active),
		.win_len_q (win_len_q)
	);

	core_array #(
		.N_CORES (N_CORES)
	) i_array (
		.clk         (clk),
		.rst         (rst),
		.run         (active),
		.win_len     (win_len_q),
		.sample_in   (sample_in),
		.weight_wr   (weight_wr),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.core_result (core_result),
		.core_code   (core_code)
	);

	result_arbiter #(
		.N_CORES (N_CORES)
	) i_arb (
		.clk         (clk),
		.rst         (rst),
		.core_result (core_result),
		.core_code   (core_code),
		.result      (result),
		.result_code (result_code),
		.result_core (result_core),
		.drop_count  (drop_count)
	);

endmodule

// File: bench/multicore_chk.sv
module multicore_chk #(
	parameter int N_CORES = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic [N_CORES-1:0]  active,
	input  mc_pkg::out_code_t   result_code,
	input  logic [15:0]         drop_count
);

	int unsigned fail_count = 0; // Read by the testbench at the end of the run.

	a_code_after_rst: assert property (@(posedge clk) rst |=> result_code == mc_pkg::OUT_NONE)
		else begin
			fail_count++;
			$error("result_code not OUT_NONE after a reset cycle");
		end

	// Cores are only released, never stopped, until the next reset.
	a_active_keeps: assert property (@(posedge clk)
		!rst |=> (active & $past(active)) == $past(active))
		else begin
			fail_count++;
			$error("active lost a bit without reset");
		end

	a_drop_grows: assert property (@(posedge clk) !rst |=> drop_count >= $past(drop_count))
		else begin
			fail_count++;
			$error("drop_count decreased without reset");
		end

endmodule

bind multicore multicore_chk #(
	.N_CORES (N_CORES)
) i_chk (
	.clk         (clk),
	.rst         (rst),
	.active      (active),
	.result_code (result_code),
	.drop_count  (drop_count)
);

// File: bench/multicore_tb.sv
module multicore_tb;

	localparam int N_CORES    = 4;
	localparam int STAGGER    = 15;
	localparam int LOG_LEN    = 8192;
	localparam int WAIT_LIMIT = 200;
	localparam longint RES_MAX = (longint'(1) << 27) - 1;
	localparam longint RES_MIN = -(longint'(1) << 27);

	logic               clk;
	logic               rst;
	mc_pkg::sample_t    sample_in;
	logic               start;
	mc_pkg::win_len_t   win_len;
	logic               weight_wr;
	logic [1:0]         weight_addr;
	mc_pkg::weight_t    weight_data;
	mc_pkg::result_t    result;
	mc_pkg::out_code_t  result_code;
	logic [1:0]         result_core;
	logic [N_CORES-1:0] active;
	logic [15:0]        drop_count;

	integer          seed = 32'h172c;
	int              edge_num = 0;
	int              sample_mode; // 0 gives full range samples, 1 gives large positive ones.
	mc_pkg::sample_t sample_log [LOG_LEN]; // Indexed by the edge that takes the sample.

	// Reference model state.
	int start_edge;
	int win;
	int search_edge;
	int exp_drops;
	int exp_weight [N_CORES];

	int                dq_edge [$];
	int                dq_core [$];
	mc_pkg::result_t   dq_result [$];
	mc_pkg::out_code_t dq_code [$];
	logic [15:0]       dq_drop [$];

	int errors;
	int checks;
	int tests;

	multicore #(
		.N_CORES (N_CORES),
		.STAGGER (STAGGER)
	) i_dut (
		.clk         (clk),
		.rst         (rst),
		.sample_in   (sample_in),
		.start       (start),
		.win_len     (win_len),
		.weight_wr   (weight_wr),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.result      (result),
		.result_code (result_code),
		.result_core (result_core),
		.active      (active),
		.drop_count  (drop_count)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		edge_num <= edge_num + 1;
	end

	always @(posedge clk) begin
		#1;
		if (sample_mode == 1) begin
			sample_in = mc_pkg::sample_t'(32'h20000 | ($random(seed) & 32'h1ffff));
		end else begin
			sample_in = mc_pkg::sample_t'($random(seed));
		end
		if (edge_num + 1 < LOG_LEN) begin
			sample_log[edge_num + 1] = sample_in; // Taken at the next edge.
		end
	end

	// Outputs are settled at the falling edge.
	always @(negedge clk) begin
		if (!rst && result_code != mc_pkg::OUT_NONE) begin
			dq_edge.push_back(edge_num);
			dq_core.push_back(int'(result_core));
			dq_result.push_back(result);
			dq_code.push_back(result_code);
			dq_drop.push_back(drop_count);
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		start = 1'b0;
		weight_wr = 1'b0;
		repeat (4) step();
		rst = 1'b0;
		dq_edge.delete();
		dq_core.delete();
		dq_result.delete();
		dq_code.delete();
		dq_drop.delete();
		for (int c = 0; c < N_CORES; c++) begin
			exp_weight[c] = 1;
		end
		exp_drops = 0;
		start_edge = -1;
	endtask

	task automatic write_weight(input int core, input int value);
		weight_wr = 1'b1;
		weight_addr = 2'(core);
		weight_data = mc_pkg::weight_t'(value);
		step();
		weight_wr = 1'b0;
		exp_weight[core] = value;
	endtask

	task automatic start_run(input int len);
		win_len = mc_pkg::win_len_t'(len);
		start = 1'b1;
		start_edge = edge_num + 1;
		step();
		start = 1'b0;
		win = len;
		search_edge = start_edge + 1;
	endtask

	function automatic logic [N_CORES-1:0] expected_active(input int at_edge);
		logic [N_CORES-1:0] mask;
		mask = '0;
		for (int c = 0; c < N_CORES; c++) begin
			if (start_edge >= 0 && at_edge >= start_edge + c * STAGGER) begin
				mask[c] = 1'b1;
			end
		end
		return mask;
	endfunction

	// Finds the next edge on which at least one core takes the last sample of a window.
	task automatic next_window(output int last_edge, output int core, output int others);
		int d;
		int n_end;
		last_edge = -1;
		core = -1;
		n_end = 0;
		while (last_edge < 0) begin
			core = -1;
			n_end = 0;
			for (int c = 0; c < N_CORES; c++) begin
				d = search_edge - start_edge - c * STAGGER;
				if (d >= win && d % win == 0) begin
					n_end++;
					if (core < 0) begin
						core = c;
					end
				end
			end
			if (n_end > 0) begin
				last_edge = search_edge;
			end
			search_edge++;
		end
		others = n_end - 1;
	endtask

	task automatic expected_result(input int core, input int last_edge,
		output mc_pkg::result_t value, output mc_pkg::out_code_t code);
		longint sum;
		sum = 0;
		for (int e = last_edge - win + 1; e <= last_edge; e++) begin
			sum += longint'(sample_log[e]) * exp_weight[core];
		end
		code = mc_pkg::OUT_RESULT;
		if (sum > RES_MAX) begin
			sum = RES_MAX;
			code = mc_pkg::OUT_SAT;
		end else if (sum < RES_MIN) begin
			sum = RES_MIN;
			code = mc_pkg::OUT_SAT;
		end
		value = mc_pkg::result_t'(sum);
	endtask

	task automatic check_deliveries(input int count);
		int last_edge;
		int core;
		int others;
		int waited;
		mc_pkg::result_t value;
		mc_pkg::out_code_t code;
		for (int i = 0; i < count; i++) begin
			next_window(last_edge, core, others);
			exp_drops = (exp_drops + others > 65535) ? 65535 : exp_drops + others;
			waited = 0;
			while (dq_edge.size() == 0 && waited < WAIT_LIMIT) begin
				step();
				waited++;
			end
			if (dq_edge.size() == 0) begin
				errors++;
				$display("ERROR no result arrived within %0d cycles", WAIT_LIMIT);
				return;
			end
			expected_result(core, last_edge, value, code);
			check_value("result_code edge", dq_edge.pop_front(), last_edge + 1);
			check_value("result_core", dq_core.pop_front(), core);
			check_value("result", dq_result.pop_front(), value);
			check_value("result_code", dq_code.pop_front(), code);
			check_value("drop_count", dq_drop.pop_front(), exp_drops);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_before);
	endtask

	task automatic test_idle();
		int err0;
		err0 = errors;
		apply_reset();
		repeat (20) begin
			step();
			check_value("active", active, 0);
			check_value("result_code", result_code, mc_pkg::OUT_NONE);
			check_value("drop_count", drop_count, 0);
		end
		finish_test("idle after reset", err0);
	endtask

	task automatic test_unit_weights();
		int err0;
		err0 = errors;
		sample_mode = 0;
		apply_reset();
		start_run(16);
		for (int k = 0; k <= 3 * STAGGER + 2; k++) begin
			check_value("active", active, expected_active(edge_num));
			step();
		end
		check_deliveries(8);
		finish_test("unit weights and release order", err0);
	endtask

	task automatic test_weights();
		int err0;
		err0 = errors;
		sample_mode = 0;
		apply_reset();
		write_weight(0, 3);
		write_weight(1, -2);
		write_weight(2, 0);
		write_weight(3, 5);
		start_run(16);
		check_deliveries(8);
		finish_test("per-core weights", err0);
	endtask

	task automatic test_saturation();
		int err0;
		err0 = errors;
		sample_mode = 1;
		apply_reset();
		write_weight(0, 127);
		write_weight(1, 127);
		write_weight(2, -127); // Negative weights drive these cores to the lower limit.
		write_weight(3, -127);
		start_run(16);
		check_deliveries(8);
		sample_mode = 0;
		finish_test("saturation", err0);
	endtask

	task automatic test_collisions();
		int err0;
		err0 = errors;
		sample_mode = 0;
		apply_reset();
		start_run(STAGGER);
		check_deliveries(10);
		finish_test("coinciding windows", err0);
	endtask

	task automatic test_restart();
		int err0;
		err0 = errors;
		sample_mode = 0;
		apply_reset();
		start_run(16);
		check_deliveries(3);
		win_len = 5'd5;
		start = 1'b1; // Ignored while the sequencer runs.
		step();
		start = 1'b0;
		check_deliveries(5);
		check_value("active", active, expected_active(edge_num));
		apply_reset();
		start_run(7);
		check_deliveries(8);
		finish_test("restart with new window length", err0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		win_len = 5'd16;
		weight_wr = 1'b0;
		weight_addr = '0;
		weight_data = '0;
		sample_in = '0;
		sample_mode = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		for (int i = 0; i < LOG_LEN; i++) begin
			sample_log[i] = '0;
		end
		apply_reset();
		test_idle();
		test_unit_weights();
		test_weights();
		test_saturation();
		test_collisions();
		test_restart();
		errors += int'(i_dut.i_chk.fail_count);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(40 * 6000);
		$display("ERROR simulation did not finish within the time limit");
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: project.f
src/mc_pkg.sv
src/start_sequencer.sv
src/neuron_core.sv
src/core_array.sv
src/result_arbiter.sv
src/multicore.sv
bench/multicore_chk.sv
bench/multicore_tb.sv

// File: Makefile
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module multicore_tb -Mdir $(BUILD_DIR) -o multicore_tb
	./$(BUILD_DIR)/multicore_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
